// ==== common/disp_pkg.sv ====
`default_nettype none

package disp_pkg;

  // clk_5M cycles each digit stays lit
  localparam int SCAN_DIV = 16;

  // width of the scan divider counter
  localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

  // digits on the board
  localparam int NUM_DIGITS = 8;

  // word offsets inside the display window
  localparam logic [3:0] DISP_ADDR = 4'd0;
  localparam logic [3:0] LED_ADDR  = 4'd1;

  // segments all off, active low
  localparam logic [6:0] SEG_BLANK = 7'b1111111;

  // anode states, value is the active-low anode pattern
  // one bit low per digit, a0 is the rightmost digit
  typedef enum logic [7:0] {
    a0 = 8'b1111_1110,
    a1 = 8'b1111_1101,
    a2 = 8'b1111_1011,
    a3 = 8'b1111_0111,
    a4 = 8'b1110_1111,
    a5 = 8'b1101_1111,
    a6 = 8'b1011_1111,
    a7 = 8'b0111_1111
  } an_state_e;

  // single-cycle write strobe from the memory controller
  // no ack, no back-pressure
  typedef struct packed {
    // write strobe
    logic        wea;
    // word offset
    logic [3:0]  addr;
    // write data
    logic [31:0] din;
  } mmio_wr_t;

endpackage

`default_nettype wire

// ==== logic/scan_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module scan_timer (
  input  logic clk_5M,
  input  logic reset,
  output logic scan_tick
);

  // free-running divide counter
  logic [disp_pkg::SCAN_CNT_W-1:0] scan_cnt;

  // terminal count of the divider
  logic cnt_last;

  assign cnt_last = (scan_cnt == disp_pkg::SCAN_CNT_W'(disp_pkg::SCAN_DIV - 1));

  // counts 0 .. SCAN_DIV-1 then wraps
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      scan_cnt <= '0;
    end else if (cnt_last) begin
      scan_cnt <= '0;
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  // one cycle high per wrap
  // first tick in cycle SCAN_DIV-1 after reset, so the
  // anode moves on the SCAN_DIV-th edge
  assign scan_tick = cnt_last;

endmodule

`default_nettype wire

// ==== display/digit_scan_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module digit_scan_fsm (
  input  logic                clk_5M,
  input  logic                reset,
  input  logic                scan_tick,
  output disp_pkg::an_state_e an_state,
  output logic                frame_start
);

  // current and next anode state
  disp_pkg::an_state_e an_cur;
  disp_pkg::an_state_e an_nxt;

  // state register
  // steps only on the scan tick
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      an_cur <= disp_pkg::a0;
    end else if (scan_tick) begin
      an_cur <= an_nxt;
    end
  end

  // rotation a0 -> a7 -> a0
  always_comb begin
    case (an_cur)
      disp_pkg::a0: begin
        an_nxt = disp_pkg::a1;
      end
      disp_pkg::a1: begin
        an_nxt = disp_pkg::a2;
      end
      disp_pkg::a2: begin
        an_nxt = disp_pkg::a3;
      end
      disp_pkg::a3: begin
        an_nxt = disp_pkg::a4;
      end
      disp_pkg::a4: begin
        an_nxt = disp_pkg::a5;
      end
      disp_pkg::a5: begin
        an_nxt = disp_pkg::a6;
      end
      disp_pkg::a6: begin
        an_nxt = disp_pkg::a7;
      end
      disp_pkg::a7: begin
        an_nxt = disp_pkg::a0;
      end
      // stray pattern, restart the scan
      default: begin
        an_nxt = disp_pkg::a0;
      end
    endcase
  end

  assign an_state = an_cur;

  // last digit plus tick marks the frame boundary
  // the decoder latches its word on this edge
  assign frame_start = (an_cur == disp_pkg::a7) & scan_tick;

endmodule

`default_nettype wire

// ==== display/seg_digit_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg_digit_decode (
  input  logic                clk_5M,
  input  logic                reset,
  input  disp_pkg::an_state_e an_state,
  input  logic                frame_start,
  input  logic [31:0]         disp_word,
  output logic [6:0]          sev_out
);

  // word held for one whole frame
  logic [31:0] frame_word;

  // nibble of the lit digit
  logic [3:0] nibble;

  // anode pattern matched a digit
  logic digit_hit;

  // new word only at a frame boundary
  // so all eight digits show the same value
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      frame_word <= '0;
    end else if (frame_start) begin
      frame_word <= disp_word;
    end
  end

  // digit k has anode bit k low, shows bits 4k+3:4k
  always_comb begin
    digit_hit = 1'b0;
    nibble    = 4'h0;
    for (int k = 0; k < disp_pkg::NUM_DIGITS; k++) begin
      if (~an_state == (8'b1 << k)) begin
        digit_hit = 1'b1;
        nibble    = frame_word[4*k +: 4];
      end
    end
  end

  // hex to segments, active low, segment a in bit 6
  always_comb begin
    if (!digit_hit) begin
      sev_out = disp_pkg::SEG_BLANK;
    end else begin
      case (nibble)
        4'h0: sev_out = 7'b0000001;
        4'h1: sev_out = 7'b1001111;
        4'h2: sev_out = 7'b0010010;
        4'h3: sev_out = 7'b0000110;
        4'h4: sev_out = 7'b1001100;
        4'h5: sev_out = 7'b0100100;
        4'h6: sev_out = 7'b0100000;
        4'h7: sev_out = 7'b0001111;
        4'h8: sev_out = 7'b0000000;
        4'h9: sev_out = 7'b0000100;
        4'ha: sev_out = 7'b0001000;
        4'hb: sev_out = 7'b1100000;
        4'hc: sev_out = 7'b0110001;
        4'hd: sev_out = 7'b1000010;
        4'he: sev_out = 7'b0110000;
        4'hf: sev_out = 7'b0111000;
        default: sev_out = disp_pkg::SEG_BLANK;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/mmio_display_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module mmio_display_regs (
  input  logic              clk_5M,
  input  logic              reset,
  input  disp_pkg::mmio_wr_t mmio_wr,
  input  logic              debug,
  input  logic              prog,
  input  logic [31:0]       debug_word,
  output logic [31:0]       disp_word,
  output logic [15:0]       led
);

  // software-visible registers
  logic [31:0] disp_reg;
  logic [15:0] led_reg;

  // per-register write enables
  logic disp_we;
  logic led_we;

  // core owns the display
  logic core_sel;

  // address decode of the strobe
  // anything outside the two offsets falls through
  always_comb begin
    disp_we = 1'b0;
    led_we  = 1'b0;
    if (mmio_wr.wea) begin
      if (mmio_wr.addr == disp_pkg::DISP_ADDR) begin
        disp_we = 1'b1;
      end
      if (mmio_wr.addr == disp_pkg::LED_ADDR) begin
        led_we = 1'b1;
      end
    end
  end

  // display register
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      disp_reg <= '0;
    end else if (disp_we) begin
      disp_reg <= mmio_wr.din;
    end
  end

  // led register holds the low half of the write data
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      led_reg <= '0;
    end else if (led_we) begin
      led_reg <= mmio_wr.din[15:0];
    end
  end

  // straight out to the board leds
  assign led = led_reg;

  // debug or prog hands the display to the core
  assign core_sel = debug | prog;

  // combinational source select
  // core debug word beats the software word
  always_comb begin
    if (core_sel) begin
      disp_word = debug_word;
    end else begin
      disp_word = disp_reg;
    end
  end

endmodule

`default_nettype wire

// ==== logic/disp_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module disp_top (
  input  logic               clk_5M,
  input  logic               reset,
  input  disp_pkg::mmio_wr_t mmio_wr,
  input  logic               debug,
  input  logic               prog,
  input  logic [31:0]        debug_word,
  output logic [7:0]         an,
  output logic [6:0]         sev_out,
  output logic [15:0]        led
);

  // refresh pacing
  logic scan_tick;

  // last digit of the frame with tick
  logic frame_start;

  // lit digit
  disp_pkg::an_state_e an_state;

  // word after source select
  logic [31:0] disp_word;

  // digit refresh divider
  scan_timer scan_timer0 (
    .clk_5M    (clk_5M),
    .reset     (reset),
    .scan_tick (scan_tick)
  );

  // anode rotation
  digit_scan_fsm digit_scan_fsm0 (
    .clk_5M      (clk_5M),
    .reset       (reset),
    .scan_tick   (scan_tick),
    .an_state    (an_state),
    .frame_start (frame_start)
  );

  // software registers and debug override
  mmio_display_regs mmio_display_regs0 (
    .clk_5M     (clk_5M),
    .reset      (reset),
    .mmio_wr    (mmio_wr),
    .debug      (debug),
    .prog       (prog),
    .debug_word (debug_word),
    .disp_word  (disp_word),
    .led        (led)
  );

  // frame latch and segment decode
  seg_digit_decode seg_digit_decode0 (
    .clk_5M      (clk_5M),
    .reset       (reset),
    .an_state    (an_state),
    .frame_start (frame_start),
    .disp_word   (disp_word),
    .sev_out     (sev_out)
  );

  // enum value is already the anode pattern
  assign an = 8'(an_state);

endmodule

`default_nettype wire

// ==== test/tb_disp_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_disp_top;

  // cycles allowed for any single wait
  localparam int WAIT_LIMIT = 20 * disp_pkg::SCAN_DIV;

  logic               clk_5M = 1'b0;
  logic               reset;
  disp_pkg::mmio_wr_t mmio_wr;
  logic               debug;
  logic               prog;
  logic [31:0]        debug_word;
  logic [7:0]         an;
  logic [6:0]         sev_out;
  logic [15:0]        led;

  // register and frame model, owned by the compare process
  logic [31:0] model_disp;
  logic [15:0] model_led;
  logic [31:0] exp_frame;
  logic [7:0]  prev_an;

  // error counts, one per process
  int errors;
  int cmp_errors;
  int tests_run;
  int tests_failed;
  int seed;

  disp_top dut0 (
    .clk_5M     (clk_5M),
    .reset      (reset),
    .mmio_wr    (mmio_wr),
    .debug      (debug),
    .prog       (prog),
    .debug_word (debug_word),
    .an         (an),
    .sev_out    (sev_out),
    .led        (led)
  );

  // 5 MHz, 200 ns period
  always #100 clk_5M = ~clk_5M;

  // hex digit to active-low segments, segment a in bit 6
  function automatic logic [6:0] seg_ref(input logic [3:0] n);
    logic [6:0] s;
    case (n)
      4'h0: s = 7'b0000001;
      4'h1: s = 7'b1001111;
      4'h2: s = 7'b0010010;
      4'h3: s = 7'b0000110;
      4'h4: s = 7'b1001100;
      4'h5: s = 7'b0100100;
      4'h6: s = 7'b0100000;
      4'h7: s = 7'b0001111;
      4'h8: s = 7'b0000000;
      4'h9: s = 7'b0000100;
      4'ha: s = 7'b0001000;
      4'hb: s = 7'b1100000;
      4'hc: s = 7'b0110001;
      4'hd: s = 7'b1000010;
      4'he: s = 7'b0110000;
      4'hf: s = 7'b0111000;
    endcase
    return s;
  endfunction

  // anode pattern to digit index, -1 if not exactly one bit low
  function automatic int digit_of(input logic [7:0] pattern);
    int d;
    d = -1;
    for (int i = 0; i < disp_pkg::NUM_DIGITS; i++) begin
      if (pattern == ~(8'b1 << i)) begin
        d = i;
      end
    end
    return d;
  endfunction

  // word the display should pick up at the next frame
  function automatic logic [31:0] expected_word(input logic [31:0] reg_word,
                                                input logic dbg, input logic prg,
                                                input logic [31:0] core_word);
    if (dbg || prg) begin
      return core_word;
    end
    return reg_word;
  endfunction

  function automatic int total_errors();
    return errors + cmp_errors;
  endfunction

  // compare process, samples 1 ns after each rising edge
  always @(posedge clk_5M) begin
    int k;
    #1;
    if (reset) begin
      model_disp = '0;
      model_led  = '0;
      exp_frame  = '0;
      prev_an    = disp_pkg::a0;
    end else begin
      // a7 -> a0 is the latch edge, inputs are still those seen by it
      if (prev_an == disp_pkg::a7 && an == disp_pkg::a0) begin
        exp_frame = expected_word(model_disp, debug, prog, debug_word);
      end
      // strobe taken on this edge
      if (mmio_wr.wea && mmio_wr.addr == disp_pkg::DISP_ADDR) begin
        model_disp = mmio_wr.din;
      end
      if (mmio_wr.wea && mmio_wr.addr == disp_pkg::LED_ADDR) begin
        model_led = mmio_wr.din[15:0];
      end
      k = digit_of(an);
      if (k < 0) begin
        $display("FAIL t=%0t an expected a single low bit got %b", $time, an);
        cmp_errors++;
      end else if (sev_out !== seg_ref(exp_frame[4*k +: 4])) begin
        $display("FAIL t=%0t sev_out expected %b got %b", $time,
                 seg_ref(exp_frame[4*k +: 4]), sev_out);
        cmp_errors++;
      end
      if (led !== model_led) begin
        $display("FAIL t=%0t led expected %h got %h", $time, model_led, led);
        cmp_errors++;
      end
      prev_an = an;
    end
  end

  // edges until an moves, bounded
  task automatic wait_an_change(output int cycles);
    logic [7:0] start_an;
    logic       moved;
    start_an = an;
    moved    = 1'b0;
    cycles   = 0;
    while (!moved && cycles < WAIT_LIMIT) begin
      @(posedge clk_5M);
      #1;
      cycles++;
      moved = (an != start_an);
    end
    if (!moved) begin
      $display("t=%0t timeout, the anode did not change within %0d cycles",
               $time, WAIT_LIMIT);
      errors++;
    end
  endtask

  // stops just after the next a7 -> a0 edge
  task automatic wait_frame_boundary;
    logic [7:0] last_an;
    logic       found;
    int         cycles;
    last_an = an;
    found   = 1'b0;
    cycles  = 0;
    while (!found && cycles < WAIT_LIMIT) begin
      @(posedge clk_5M);
      #1;
      cycles++;
      found   = (last_an == disp_pkg::a7 && an == disp_pkg::a0);
      last_an = an;
    end
    if (!found) begin
      $display("t=%0t timeout, no frame boundary within %0d cycles", $time, WAIT_LIMIT);
      errors++;
    end
  endtask

  // next full frame must show word on every digit
  task automatic check_frame(input logic [31:0] word);
    int         cycles;
    logic [6:0] exp_seg;
    wait_frame_boundary();
    for (int k = 0; k < disp_pkg::NUM_DIGITS; k++) begin
      exp_seg = seg_ref(word[4*k +: 4]);
      if (digit_of(an) != k) begin
        $display("FAIL t=%0t an expected %b got %b", $time, ~(8'b1 << k), an);
        errors++;
      end
      if (sev_out !== exp_seg) begin
        $display("FAIL t=%0t sev_out expected %b got %b", $time, exp_seg, sev_out);
        errors++;
      end
      if (k < disp_pkg::NUM_DIGITS - 1) begin
        wait_an_change(cycles);
      end
    end
  endtask

  // one-cycle strobe, driven on falling edges
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    @(negedge clk_5M);
    mmio_wr.wea  = 1'b1;
    mmio_wr.addr = addr;
    mmio_wr.din  = data;
    @(negedge clk_5M);
    mmio_wr.wea = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (total_errors() == errs_before) begin
      $display("test %0s: ok", name);
    end else begin
      tests_failed++;
      $display("test %0s: %0d errors", name, total_errors() - errs_before);
    end
  endtask

  initial begin
    int          errs_before;
    int          cycles;
    int          digit;
    logic [31:0] word;
    reset        = 1'b1;
    mmio_wr      = '0;
    debug        = 1'b0;
    prog         = 1'b0;
    debug_word   = '0;
    errors       = 0;
    cmp_errors   = 0;
    tests_run    = 0;
    tests_failed = 0;
    seed         = 32'hc659_d569;

    // reset state, checked inside reset and on the first free edge
    errs_before = total_errors();
    repeat (3) @(negedge clk_5M);
    if (an !== disp_pkg::a0 || sev_out !== 7'b0000001 || led !== 16'h0000) begin
      $display("FAIL t=%0t an/sev_out/led expected %b/%b/%h got %b/%b/%h", $time,
               disp_pkg::a0, 7'b0000001, 16'h0000, an, sev_out, led);
      errors++;
    end
    @(negedge clk_5M);
    reset = 1'b0;
    @(posedge clk_5M);
    #1;
    if (an !== disp_pkg::a0 || sev_out !== 7'b0000001 || led !== 16'h0000) begin
      $display("FAIL t=%0t an/sev_out/led expected %b/%b/%h got %b/%b/%h", $time,
               disp_pkg::a0, 7'b0000001, 16'h0000, an, sev_out, led);
      errors++;
    end
    report_test("reset state", errs_before);

    // anode rotation and spacing
    errs_before = total_errors();
    wait_an_change(cycles);
    // one edge already spent on the reset check
    if (cycles + 1 != disp_pkg::SCAN_DIV) begin
      $display("FAIL t=%0t first scan interval expected %0d got %0d", $time,
               disp_pkg::SCAN_DIV, cycles + 1);
      errors++;
    end
    if (an !== disp_pkg::a1) begin
      $display("FAIL t=%0t an expected %b got %b", $time, disp_pkg::a1, an);
      errors++;
    end
    for (int i = 0; i < 2 * disp_pkg::NUM_DIGITS; i++) begin
      digit = digit_of(an);
      wait_an_change(cycles);
      if (cycles != disp_pkg::SCAN_DIV) begin
        $display("FAIL t=%0t scan interval expected %0d got %0d", $time,
                 disp_pkg::SCAN_DIV, cycles);
        errors++;
      end
      if (digit_of(an) != (digit + 1) % disp_pkg::NUM_DIGITS) begin
        $display("FAIL t=%0t an expected %b got %b", $time,
                 ~(8'b1 << ((digit + 1) % disp_pkg::NUM_DIGITS)), an);
        errors++;
      end
    end
    report_test("anode rotation", errs_before);

    // display write, old word holds until the boundary
    errs_before = total_errors();
    write_reg(disp_pkg::DISP_ADDR, 32'h89ab_cdef);
    if (sev_out !== seg_ref(4'h0)) begin
      $display("FAIL t=%0t sev_out expected %b got %b", $time, seg_ref(4'h0), sev_out);
      errors++;
    end
    check_frame(32'h89ab_cdef);
    report_test("display write", errs_before);

    // core word overrides, then the register comes back
    errs_before = total_errors();
    @(negedge clk_5M);
    debug      = 1'b1;
    debug_word = 32'h1357_9bdf;
    check_frame(32'h1357_9bdf);
    @(negedge clk_5M);
    debug      = 1'b0;
    prog       = 1'b1;
    debug_word = 32'h2468_ace0;
    check_frame(32'h2468_ace0);
    @(negedge clk_5M);
    prog = 1'b0;
    check_frame(32'h89ab_cdef);
    report_test("debug override", errs_before);

    // led write, stray address, strobe low
    errs_before = total_errors();
    write_reg(disp_pkg::LED_ADDR, 32'h1234_a5c3);
    if (led !== 16'ha5c3) begin
      $display("FAIL t=%0t led expected %h got %h", $time, 16'ha5c3, led);
      errors++;
    end
    write_reg(4'd5, 32'hffff_ffff);
    if (led !== 16'ha5c3) begin
      $display("FAIL t=%0t led expected %h got %h", $time, 16'ha5c3, led);
      errors++;
    end
    @(negedge clk_5M);
    mmio_wr.wea  = 1'b0;
    mmio_wr.addr = disp_pkg::LED_ADDR;
    mmio_wr.din  = 32'hdead_beef;
    @(negedge clk_5M);
    if (led !== 16'ha5c3) begin
      $display("FAIL t=%0t led expected %h got %h", $time, 16'ha5c3, led);
      errors++;
    end
    check_frame(32'h89ab_cdef);
    report_test("led and ignored writes", errs_before);

    // random display words
    errs_before = total_errors();
    for (int i = 0; i < 10; i++) begin
      word = $random(seed);
      write_reg(disp_pkg::DISP_ADDR, word);
      check_frame(word);
    end
    report_test("random words", errs_before);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
common/disp_pkg.sv
logic/scan_timer.sv
display/digit_scan_fsm.sv
display/seg_digit_decode.sv
logic/mmio_display_regs.sv
logic/disp_top.sv
test/tb_disp_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_disp_top -f flist.f

sim_out=$(./obj_dir/Vtb_disp_top)
echo "$sim_out"

if grep -qx "Simulation completed successfully" <<< "$sim_out"; then
  echo "run_sim: PASS"
else
  echo "run_sim: FAIL"
  exit 1
fi
